/* rtl/dnc_macros.svh */
// DNC allocation weighting constants
`ifndef DNC_MACROS_SVH
`define DNC_MACROS_SVH

// Width of one scratch word and of a Q1.15 usage fraction
`define DNC_DATA_WIDTH 16

// Largest usage vector handled in one run
`define DNC_MAX_N 16

// Two regions of 16 words, usage then free list
`define DNC_ADDR_WIDTH 5

// Q1.15 one
`define DNC_ONE 16'h8000

`endif

/* rtl/dnc_fixed_pkg.sv */
// DNC fixed point types
`include "dnc_macros.svh"

package dnc_fixed_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////////////////////////////////////////

  // Q1.15 fraction, 0x8000 is one
  typedef logic [`DNC_DATA_WIDTH-1:0] usage_t;

  // Location number within the usage vector
  typedef logic [3:0] index_t;

  ////////////////////////////////////////////////////////////////////////////
  // Scratch word
  ////////////////////////////////////////////////////////////////////////////

  // Usage region holds fractions, free-list region holds indices
  typedef union packed {
    usage_t frac;
    struct packed {
      logic [`DNC_DATA_WIDTH-$bits(index_t)-1:0] zero;
      index_t                                    idx;
    } phi;
  } scratch_word_t;

endpackage

/* rtl/dnc_scratch_pkg.sv */
// DNC scratch memory map
`include "dnc_macros.svh"

package dnc_scratch_pkg;

  // Scratch address
  typedef logic [`DNC_ADDR_WIDTH-1:0] addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Region bases
  ////////////////////////////////////////////////////////////////////////////

  // Usage of location k at USAGE_BASE + k
  localparam addr_t USAGE_BASE = 5'd0;
  // Free-list entry j at PHI_BASE + j
  localparam addr_t PHI_BASE = 5'd16;

  // Requester slots, also the bit position in req, we and grant
  typedef enum logic [1:0] {
    LOADER  = 2'd0,
    SORTER  = 2'd1,
    PRODUCT = 2'd2
  } requester_t;

endpackage

/* rtl/dnc_shared_scratch.sv */
// Arbitrated scratch RAM
`timescale 1ns/1ps
`include "dnc_macros.svh"

module dnc_shared_scratch (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic [2:0]                   req,
  input  logic [2:0]                   we,
  input  dnc_scratch_pkg::addr_t       addr_loader,
  input  dnc_scratch_pkg::addr_t       addr_sorter,
  input  dnc_scratch_pkg::addr_t       addr_product,
  input  dnc_fixed_pkg::scratch_word_t wdata_loader,
  input  dnc_fixed_pkg::scratch_word_t wdata_sorter,
  output logic [2:0]                   grant,
  output dnc_fixed_pkg::scratch_word_t rdata
);

  // Single port storage, both regions
  dnc_fixed_pkg::scratch_word_t mem [0:(1 << `DNC_ADDR_WIDTH)-1];

  dnc_scratch_pkg::requester_t rr_ptr;
  dnc_scratch_pkg::requester_t cand_1;
  dnc_scratch_pkg::requester_t cand_2;
  dnc_scratch_pkg::requester_t sel;
  logic                         busy;
  dnc_scratch_pkg::addr_t       acc_addr;
  dnc_fixed_pkg::scratch_word_t acc_wdata;

  // Next requester in ring order
  function automatic dnc_scratch_pkg::requester_t rotate(input dnc_scratch_pkg::requester_t r);
    case (r)
      dnc_scratch_pkg::LOADER: return dnc_scratch_pkg::SORTER;
      dnc_scratch_pkg::SORTER: return dnc_scratch_pkg::PRODUCT;
      default:                 return dnc_scratch_pkg::LOADER;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////////////////////

  // First pending requester at or after the pointer
  always_comb begin
    cand_1 = rotate(rr_ptr);
    cand_2 = rotate(cand_1);
    if (req[rr_ptr]) sel = rr_ptr;
    else if (req[cand_1]) sel = cand_1;
    else sel = cand_2;
    busy  = |req;
    grant = busy ? (3'b001 << sel) : 3'b000;
  end

  // Winner's address and data
  always_comb begin
    acc_wdata = '0;
    case (sel)
      dnc_scratch_pkg::LOADER: begin
        acc_addr  = addr_loader;
        acc_wdata = wdata_loader;
      end
      dnc_scratch_pkg::SORTER: begin
        acc_addr  = addr_sorter;
        acc_wdata = wdata_sorter;
      end
      default: acc_addr = addr_product;   // read only peer
    endcase
  end

  // Pointer moves past the winner
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rr_ptr <= dnc_scratch_pkg::LOADER;
    end else if (busy) begin
      rr_ptr <= rotate(sel);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // RAM access
  ////////////////////////////////////////////////////////////////////////////

  // One access per cycle, read data next cycle
  always_ff @(posedge CLK) begin
    if (busy) begin
      if (we[sel]) mem[acc_addr] <= acc_wdata;
      else rdata <= mem[acc_addr];
    end
  end

endmodule

/* rtl/dnc_sort_vector.sv */
// Usage selection sorter
`timescale 1ns/1ps
`include "dnc_macros.svh"

module dnc_sort_vector (
  input  logic                                   CLK,
  input  logic                                   RST,
  input  logic                                   sort_start,
  input  logic [$bits(dnc_fixed_pkg::index_t):0] size_n,
  input  logic                                   grant,
  input  dnc_fixed_pkg::scratch_word_t           rdata,
  output logic                                   req,
  output logic                                   we,
  output dnc_scratch_pkg::addr_t                 addr,
  output dnc_fixed_pkg::scratch_word_t           wdata,
  output logic [4:0]                             phi_count,
  output logic                                   sort_done
);

  // FSM encoding
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_READ  = 2'd1;
  localparam logic [1:0] ST_CMP   = 2'd2;
  localparam logic [1:0] ST_WRITE = 2'd3;

  logic [1:0]                state;
  logic [4:0]                scan;       // location under test
  logic [`DNC_MAX_N-1:0]     taken;      // already in free list
  logic                      found;      // best_* valid this pass
  dnc_fixed_pkg::usage_t     best_val;
  dnc_fixed_pkg::index_t     best_idx;

  ////////////////////////////////////////////////////////////////////////////
  // Scratch requests
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    req   = 1'b0;
    we    = 1'b0;
    addr  = dnc_scratch_pkg::USAGE_BASE + scan;
    wdata = '0;
    wdata.phi.idx = best_idx;
    case (state)
      // Read only untaken locations
      ST_READ: req = (scan != size_n) && !taken[scan[3:0]];
      ST_WRITE: begin
        req  = 1'b1;
        we   = 1'b1;
        addr = dnc_scratch_pkg::PHI_BASE + phi_count;
      end
      default: req = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pass control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ST_IDLE;
      scan      <= '0;
      taken     <= '0;
      found     <= 1'b0;
      phi_count <= '0;
      sort_done <= 1'b0;
    end else begin
      sort_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (sort_start) begin
            taken     <= '0;
            phi_count <= '0;
            scan      <= '0;
            found     <= 1'b0;
            state     <= ST_READ;
          end
        end
        ST_READ: begin
          // End of scan, winner is known
          if (scan == size_n) state <= ST_WRITE;
          else if (taken[scan[3:0]]) scan <= scan + 5'd1;
          else if (grant) state <= ST_CMP;
        end
        ST_CMP: begin
          found <= 1'b1;
          scan  <= scan + 5'd1;
          state <= ST_READ;
        end
        default: begin
          if (grant) begin
            taken[best_idx] <= 1'b1;
            phi_count       <= phi_count + 5'd1;
            scan            <= '0;
            found           <= 1'b0;
            if (phi_count + 5'd1 == size_n) begin
              sort_done <= 1'b1;
              state     <= ST_IDLE;
            end else begin
              state <= ST_READ;
            end
          end
        end
      endcase
    end
  end

  // Strict compare keeps the lower location on a tie
  always_ff @(posedge CLK) begin
    if (state == ST_CMP && (!found || rdata.frac < best_val)) begin
      best_val <= rdata.frac;
      best_idx <= scan[3:0];
    end
  end

endmodule

/* rtl/dnc_free_product.sv */
// Free list running product engine
`timescale 1ns/1ps
`include "dnc_macros.svh"

module dnc_free_product (
  input  logic                                   CLK,
  input  logic                                   RST,
  input  logic                                   product_start,
  input  logic [$bits(dnc_fixed_pkg::index_t):0] size_n,
  input  logic [4:0]                             phi_count,
  input  logic                                   grant,
  input  dnc_fixed_pkg::scratch_word_t           rdata,
  output logic                                   req,
  output dnc_scratch_pkg::addr_t                 addr,
  output logic                                   a_enable,
  output dnc_fixed_pkg::index_t                  a_index,
  output dnc_fixed_pkg::usage_t                  a_value,
  output logic                                   product_done
);

  // FSM encoding
  localparam logic [2:0] P_IDLE = 3'd0;
  localparam logic [2:0] P_PHI  = 3'd1;   // read free-list entry j
  localparam logic [2:0] P_LOC  = 3'd2;   // capture location
  localparam logic [2:0] P_USE  = 3'd3;   // read its usage
  localparam logic [2:0] P_CALC = 3'd4;   // emit weight
  localparam logic [2:0] P_DONE = 3'd5;

  logic [2:0]                   state;
  logic [4:0]                   j;
  dnc_fixed_pkg::index_t        loc;
  dnc_fixed_pkg::usage_t        prod;        // product of earlier usages
  dnc_fixed_pkg::usage_t        one_minus;
  logic [2*`DNC_DATA_WIDTH-1:0] weight_full;
  logic [2*`DNC_DATA_WIDTH-1:0] prod_full;

  // Q1.15 multiplies, truncated by 15 bits below
  assign one_minus   = `DNC_ONE - rdata.frac;
  assign weight_full = one_minus * prod;
  assign prod_full   = prod * rdata.frac;

  // Entry j only once the sorter has written it
  assign req  = (state == P_PHI && phi_count > j) || state == P_USE;
  assign addr = (state == P_USE) ? dnc_scratch_pkg::USAGE_BASE + loc
                                 : dnc_scratch_pkg::PHI_BASE + j;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= P_IDLE;
      j            <= '0;
      a_enable     <= 1'b0;
      product_done <= 1'b0;
    end else begin
      a_enable     <= 1'b0;
      product_done <= 1'b0;
      case (state)
        P_IDLE: if (product_start) begin
          j     <= '0;
          state <= P_PHI;
        end
        P_PHI:  if (req && grant) state <= P_LOC;
        P_LOC:  state <= P_USE;
        P_USE:  if (grant) state <= P_CALC;
        P_CALC: begin
          a_enable <= 1'b1;
          j        <= j + 5'd1;
          state    <= (j + 5'd1 == size_n) ? P_DONE : P_PHI;
        end
        default: begin
          product_done <= 1'b1;
          state        <= P_IDLE;
        end
      endcase
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (state == P_IDLE && product_start) prod <= `DNC_ONE;
    if (state == P_LOC) loc <= rdata.phi.idx;
    if (state == P_CALC) begin
      a_index <= loc;
      a_value <= weight_full[`DNC_DATA_WIDTH+14:15];
      prod    <= prod_full[`DNC_DATA_WIDTH+14:15];
    end
  end

endmodule

/* rtl/dnc_allocation_weighting.sv */
// DNC allocation weighting top level
`timescale 1ns/1ps

module dnc_allocation_weighting (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  logic [4:0]            size_n,
  input  logic                  u_enable,
  input  dnc_fixed_pkg::usage_t u_value,
  output logic                  ready,
  output logic                  a_enable,
  output dnc_fixed_pkg::index_t a_index,
  output dnc_fixed_pkg::usage_t a_value
);

  // Scratch port signals, one bit per requester
  logic [2:0]                   req;
  logic [2:0]                   we;
  logic [2:0]                   grant;
  dnc_scratch_pkg::addr_t       addr_loader;
  dnc_scratch_pkg::addr_t       addr_sorter;
  dnc_scratch_pkg::addr_t       addr_product;
  dnc_fixed_pkg::scratch_word_t wdata_loader;
  dnc_fixed_pkg::scratch_word_t wdata_sorter;
  dnc_fixed_pkg::scratch_word_t rdata;

  logic                  sort_req;
  logic                  sort_we;
  logic                  prod_req;
  logic [4:0]            phi_count;
  logic                  sort_done;
  logic                  product_done;
  logic                  running;
  logic                  accept;
  logic                  run_start;     // sort_start and product_start
  logic                  sort_finished;
  logic [4:0]            run_size;      // size_n held for the run
  dnc_fixed_pkg::index_t load_ptr;

  ////////////////////////////////////////////////////////////////////////////
  // Usage loader
  ////////////////////////////////////////////////////////////////////////////

  // Loader writes only, product engine reads only
  assign req[dnc_scratch_pkg::LOADER]  = u_enable;
  assign req[dnc_scratch_pkg::SORTER]  = sort_req;
  assign req[dnc_scratch_pkg::PRODUCT] = prod_req;
  assign we[dnc_scratch_pkg::LOADER]   = 1'b1;
  assign we[dnc_scratch_pkg::SORTER]   = sort_we;
  assign we[dnc_scratch_pkg::PRODUCT]  = 1'b0;
  assign addr_loader       = dnc_scratch_pkg::USAGE_BASE + load_ptr;
  assign wdata_loader.frac = u_value;

  ////////////////////////////////////////////////////////////////////////////
  // Run sequencer
  ////////////////////////////////////////////////////////////////////////////

  assign accept = start && !running;
  // Run ends when both engines have finished
  assign ready  = product_done && sort_finished;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      running       <= 1'b0;
      run_start     <= 1'b0;
      sort_finished <= 1'b0;
      load_ptr      <= '0;
    end else begin
      run_start <= accept;
      if (accept) begin
        running       <= 1'b1;
        sort_finished <= 1'b0;
        load_ptr      <= '0;
      end else if (grant[dnc_scratch_pkg::LOADER]) begin
        load_ptr <= load_ptr + 4'd1;
      end
      if (sort_done) sort_finished <= 1'b1;
      if (ready) running <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) run_size <= size_n;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Peers and scratch
  ////////////////////////////////////////////////////////////////////////////

  dnc_shared_scratch scratch (
    .CLK(CLK), .RST(RST), .req(req), .we(we),
    .addr_loader(addr_loader), .addr_sorter(addr_sorter), .addr_product(addr_product),
    .wdata_loader(wdata_loader), .wdata_sorter(wdata_sorter),
    .grant(grant), .rdata(rdata)
  );

  dnc_sort_vector sorter (
    .CLK(CLK), .RST(RST), .sort_start(run_start), .size_n(run_size),
    .grant(grant[dnc_scratch_pkg::SORTER]), .rdata(rdata),
    .req(sort_req), .we(sort_we), .addr(addr_sorter), .wdata(wdata_sorter),
    .phi_count(phi_count), .sort_done(sort_done)
  );

  dnc_free_product product (
    .CLK(CLK), .RST(RST), .product_start(run_start), .size_n(run_size),
    .phi_count(phi_count), .grant(grant[dnc_scratch_pkg::PRODUCT]), .rdata(rdata),
    .req(prod_req), .addr(addr_product), .a_enable(a_enable),
    .a_index(a_index), .a_value(a_value), .product_done(product_done)
  );

endmodule

/* test/dnc_allocation_weighting_props.sv */
// Allocation weighting port checks
`timescale 1ns/1ps

module dnc_allocation_weighting_props (
  input logic       CLK,
  input logic       RST,
  input logic [4:0] size_n,
  input logic       ready,
  input logic       a_enable,
  input logic [3:0] a_index,
  input logic       running
);

  // Ready comes one cycle after the last weight
  assert property (@(posedge CLK) disable iff (RST) !(a_enable && ready))
    else $error("a_enable and ready high in the same cycle");

  // Emitted location lies inside the vector
  assert property (@(posedge CLK) disable iff (RST) a_enable |-> (a_index < size_n))
    else $error("a_index %0d not below size_n %0d", a_index, size_n);

  // Weights only while a run is active
  assert property (@(posedge CLK) disable iff (RST) a_enable |-> running)
    else $error("a_enable outside a run");

endmodule

bind dnc_allocation_weighting dnc_allocation_weighting_props props (
  .CLK(CLK), .RST(RST), .size_n(size_n), .ready(ready),
  .a_enable(a_enable), .a_index(a_index), .running(running)
);

/* test/dnc_allocation_weighting_tb.sv */
// Allocation weighting testbench
`timescale 1ns/1ps
`include "dnc_macros.svh"

module dnc_allocation_weighting_tb;

  // Ten runs, each at most N*N + 4N cycles times four, plus loading and reset
  localparam int NUM_RUNS   = 10;
  localparam int MAX_CYCLES = NUM_RUNS * (16 * 16 + 4 * 16) * 4 + 5000;

  logic        CLK;
  logic        RST;
  logic        start;
  logic [4:0]  size_n;
  logic        u_enable;
  logic [15:0] u_value;
  logic        ready;
  logic        a_enable;
  logic [3:0]  a_index;
  logic [15:0] a_value;

  logic [31:0] lfsr;
  int          cycles;
  logic [15:0] usage   [16];   // vector loaded in the next run
  logic [3:0]  exp_idx [16];   // reference free list
  logic [15:0] exp_val [16];   // reference weights
  logic [3:0]  got_idx [16];
  logic [15:0] got_val [16];

  dnc_allocation_weighting UUT (
    .CLK(CLK), .RST(RST), .start(start), .size_n(size_n),
    .u_enable(u_enable), .u_value(u_value), .ready(ready),
    .a_enable(a_enable), .a_index(a_index), .a_value(a_value)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_run();
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_equal(input string test, input string what,
                             input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      $display("** Error: %s %s expected 0x%04h actual 0x%04h", test, what, exp, act);
      fail_run();
    end
  endtask

  task automatic check_true(input string test, input logic cond, input string msg);
    assert (cond === 1'b1) else begin
      $display("%s: %s", test, msg);
      fail_run();
    end
  endtask

  // Hard stop if a run never completes
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge CLK);
      cycles = cycles + 1;
    end
    $display("Timeout after %0d cycles, the tests did not finish", cycles);
    fail_run();
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output logic [15:0] v);
    v = '0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);
      v = {v[14:0], lfsr[0]};
    end
  endtask

  // Stable sort by usage, then Q1.15 running product
  task automatic compute_reference(input int n);
    logic [15:0] taken;
    logic [15:0] prod;
    logic [31:0] wide;
    int          best;
    taken = '0;
    prod  = `DNC_ONE;
    for (int j = 0; j < n; j++) begin
      best = -1;
      for (int k = 0; k < n; k++) begin
        if (!taken[k] && (best < 0 || usage[k] < usage[best])) best = k;
      end
      taken[best] = 1'b1;
      exp_idx[j]  = 4'(best);
      wide        = (32'(`DNC_ONE) - 32'(usage[best])) * 32'(prod);
      exp_val[j]  = wide[30:15];
      wide        = 32'(prod) * 32'(usage[best]);
      prod        = wide[30:15];
    end
  endtask

  // Load, start, collect n weights, compare with the reference
  task automatic run_case(input string name, input int n);
    int          got;
    logic        done;
    logic [15:0] seen;
    compute_reference(n);
    for (int k = 0; k < n; k++) begin
      @(negedge CLK);
      u_enable = 1'b1;
      u_value  = usage[k];
    end
    @(negedge CLK);
    u_enable = 1'b0;
    start    = 1'b1;
    size_n   = 5'(n);
    @(negedge CLK);
    start = 1'b0;
    got   = 0;
    done  = 1'b0;
    seen  = '0;
    while (!done) begin
      @(negedge CLK);
      if (a_enable) begin
        check_true(name, got < n, "more weights than size_n");
        check_true(name, !seen[a_index], "location emitted twice");
        seen[a_index] = 1'b1;
        check_equal(name, $sformatf("a_index[%0d]", got), 16'(exp_idx[got]), 16'(a_index));
        check_equal(name, $sformatf("a_value[%0d]", got), exp_val[got], a_value);
        got_idx[got] = a_index;
        got_val[got] = a_value;
        got = got + 1;
      end
      if (ready) done = 1'b1;
    end
    check_true(name, got == n, "ready before all weights were emitted");
    // Single ready pulse, quiet afterwards
    repeat (3) begin
      @(negedge CLK);
      check_true(name, !ready && !a_enable, "output activity after ready");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_distinct();
    usage[0] = 16'h7000;
    usage[1] = 16'h1000;
    usage[2] = 16'h5000;
    usage[3] = 16'h0800;
    usage[4] = 16'h6000;
    usage[5] = 16'h2000;
    usage[6] = 16'h4000;
    usage[7] = 16'h3000;
    run_case("distinct", 8);
  endtask

  // Half usage everywhere, weights halve at each step
  task automatic test_equal();
    for (int k = 0; k < 6; k++) usage[k] = 16'h4000;
    run_case("equal", 6);
    for (int j = 0; j < 6; j++) begin
      check_equal("equal", "tie order", 16'(j), 16'(got_idx[j]));
      check_equal("equal", "geometric weight", 16'h4000 >> j, got_val[j]);
    end
  endtask

  task automatic test_boundary();
    usage[0] = `DNC_ONE;
    usage[1] = 16'h0000;
    usage[2] = `DNC_ONE;
    usage[3] = 16'h4000;
    usage[4] = 16'h0000;
    usage[5] = `DNC_ONE;
    run_case("boundary zero", 6);
    check_equal("boundary zero", "first location", 16'd1, 16'(got_idx[0]));
    check_equal("boundary zero", "first weight", `DNC_ONE, got_val[0]);
    for (int j = 1; j < 6; j++) begin
      check_equal("boundary zero", "later weight", 16'h0000, got_val[j]);
    end
    usage[0] = `DNC_ONE;
    usage[1] = 16'h2000;
    usage[2] = `DNC_ONE;
    usage[3] = 16'h4000;
    run_case("boundary full", 4);
    // Fully used locations get nothing
    for (int j = 0; j < 4; j++) begin
      if (usage[exp_idx[j]] == `DNC_ONE) begin
        check_equal("boundary full", "full usage weight", 16'h0000, got_val[j]);
      end
    end
  endtask

  task automatic test_random();
    logic [15:0] v;
    for (int r = 0; r < 4; r++) begin
      for (int k = 0; k < 16; k++) begin
        random_bits(15, v);
        usage[k] = v;
      end
      run_case($sformatf("random run %0d", r), 16);
    end
  endtask

  // Short run then longer run, pointer and state restart
  task automatic test_back_to_back();
    usage[0] = 16'h3000;
    run_case("back to back n1", 1);
    check_equal("back to back n1", "single weight", 16'h5000, got_val[0]);
    usage[0] = 16'h6000;
    usage[1] = 16'h0400;
    usage[2] = 16'h2800;
    usage[3] = 16'h7fff;
    usage[4] = 16'h1200;
    run_case("back to back n5", 5);
  endtask

  initial begin
    RST      = 1'b1;
    start    = 1'b0;
    size_n   = 5'd0;
    u_enable = 1'b0;
    u_value  = 16'h0000;
    lfsr     = 32'hf93297c1;
    // Ten rising edges in reset
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);
    test_distinct();
    test_equal();
    test_boundary();
    test_random();
    test_back_to_back();
    $display("Simulation passed");
    $finish;
  end

endmodule

/* sources.f */
+incdir+rtl
rtl/dnc_fixed_pkg.sv
rtl/dnc_scratch_pkg.sv
rtl/dnc_shared_scratch.sv
rtl/dnc_sort_vector.sv
rtl/dnc_free_product.sv
rtl/dnc_allocation_weighting.sv
test/dnc_allocation_weighting_props.sv
test/dnc_allocation_weighting_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only -Wall --timing
TOP        = dnc_allocation_weighting_tb
RTL_TOP    = dnc_allocation_weighting
FILELIST   = sources.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
